//--- rtl/sprite_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_engine_top #(
	parameter int SPRITE_COUNT = 32,
	parameter int LINE_LENGTH = 352
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_n,
	// Display timing
	input  wire logic                                   hsync,
	input  sprite_pkg::screen_pos_t                     vcnt,
	input  sprite_pkg::screen_pos_t                     hcnt,
	// Sprite attribute table
	output logic [sprite_pkg::SPR_TABLE_ADDR_W-1:0]     spr_table_addr,
	input  wire logic [7:0]                             spr_table_data,
	// Sprite image ROM
	output logic [sprite_pkg::SPR_ROM_ADDR_W-1:0]       img_rom_addr,
	input  wire logic [7:0]                             img_rom_data,
	// Palette ROM
	output logic [sprite_pkg::PAL_ADDR_W-1:0]           pal_addr,
	input  sprite_pkg::pal_color_t                      pal_data,
	// Display output and render status
	output sprite_pkg::rgb_pixel_t                      pixel,
	output logic                                        line_done
);

	import sprite_pkg::*;

	lb_write_t lb_wr;
	logic      swap;

	sprite_line_scanner #(
		.SPRITE_COUNT (SPRITE_COUNT),
		.LINE_LENGTH  (LINE_LENGTH)
	) sprite_line_scanner_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.spr_table_addr (spr_table_addr),
		.spr_table_data (spr_table_data),
		.img_rom_addr   (img_rom_addr),
		.img_rom_data   (img_rom_data),
		.pal_addr       (pal_addr),
		.pal_data       (pal_data),
		.lb_wr          (lb_wr),
		.swap           (swap),
		.line_done      (line_done)
	);

	sprite_line_buffer #(
		.LINE_LENGTH (LINE_LENGTH)
	) sprite_line_buffer_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.swap  (swap),
		.lb_wr (lb_wr),
		.hcnt  (hcnt),
		.pixel (pixel)
	);

endmodule

`default_nettype wire

//--- rtl/sprite_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_line_buffer #(
	parameter int LINE_LENGTH = 352
) (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               swap,
	input  sprite_pkg::lb_write_t   lb_wr,
	input  sprite_pkg::screen_pos_t hcnt,
	output sprite_pkg::rgb_pixel_t  pixel
);

	import sprite_pkg::*;

	localparam int DEPTH = 2 << LB_ADDR_W;

	// Two slots, selected by the top address bit
	pal_color_t lb_ram [DEPTH];

	// Slot being displayed, the other one is being rendered
	logic rd_slot;

	logic [LB_ADDR_W-1:0] rd_addr;
	logic                 rd_in_range;
	pal_color_t           rd_word;

	// Display runs one sprite width behind the buffer position
	assign rd_addr = LB_ADDR_W'(hcnt) + LB_ADDR_W'(SPRITE_SIZE);
	assign rd_in_range = (rd_addr <= LB_ADDR_W'(LINE_LENGTH));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_slot <= 1'b0;
		end
		else if (swap)
		begin
			rd_slot <= ~rd_slot;
		end
	end

	always_ff @(posedge clk)
	begin
		if (lb_wr.en)
		begin
			lb_ram[{~rd_slot, lb_wr.addr}] <= lb_wr.data;
		end
	end

	// Positions past the cleared range may hold stale sprite data
	always_ff @(posedge clk)
	begin
		if (rd_in_range)
		begin
			rd_word <= lb_ram[{rd_slot, rd_addr}];
		end
		else
		begin
			rd_word <= '0;
		end
	end

	// 5-bit channels widened by repeating their top bits
	assign pixel.alpha = rd_word.alpha;
	assign pixel.red = {rd_word.red, rd_word.red[4:2]};
	assign pixel.green = {rd_word.green, rd_word.green[4:2]};
	assign pixel.blue = {rd_word.blue, rd_word.blue[4:2]};

endmodule

`default_nettype wire

//--- rtl/sprite_line_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_line_scanner #(
	parameter int SPRITE_COUNT = 32,
	parameter int LINE_LENGTH = 352
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_n,
	input  wire logic                                   hsync,
	input  sprite_pkg::screen_pos_t                     vcnt,
	output logic [sprite_pkg::SPR_TABLE_ADDR_W-1:0]     spr_table_addr,
	input  wire logic [7:0]                             spr_table_data,
	output logic [sprite_pkg::SPR_ROM_ADDR_W-1:0]       img_rom_addr,
	input  wire logic [7:0]                             img_rom_data,
	output logic [sprite_pkg::PAL_ADDR_W-1:0]           pal_addr,
	input  sprite_pkg::pal_color_t                      pal_data,
	output sprite_pkg::lb_write_t                       lb_wr,
	output logic                                        swap,
	output logic                                        line_done
);

	import sprite_pkg::*;

	localparam int IDX_W = $clog2(SPRITE_COUNT);
	localparam int PIX_W = $clog2(SPRITE_SIZE) + 1;
	localparam int ROW_W = $clog2(SPRITE_SIZE);
	localparam int Y_W = 12;
	localparam int IMG_W = 6;

	localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(SPRITE_COUNT - 1);
	localparam logic [LB_ADDR_W-1:0] LAST_CLEAR = LB_ADDR_W'(LINE_LENGTH);

	typedef enum logic [3:0] {
		S_IDLE,
		S_CLEAR,
		S_SETUP_Y,
		S_WAIT,
		S_READ_Y_UPPER,
		S_READ_Y_LOWER,
		S_CHECK_Y,
		S_READ_X_UPPER,
		S_READ_X_LOWER,
		S_SETUP_PIXEL,
		S_GET_PIXEL,
		S_STAGE_PIXEL,
		S_WRITE_PIXEL,
		S_LINE_COMPLETE
	} scan_state_t;

	scan_state_t state;
	scan_state_t state_next;

	logic hsync_last;
	logic hsync_rise;

	logic [IDX_W-1:0] spr_index;
	logic [PIX_W-1:0] pixel_index;

	// Attributes of the sprite under test
	logic                 spr_enable;
	logic [Y_W-1:0]       spr_y;
	logic [LB_ADDR_W-1:0] spr_x;
	logic [IMG_W-1:0]     spr_image;

	// Line being rendered one sprite height ahead of the display
	logic [Y_W-1:0] spr_ya;
	logic [Y_W-1:0] spr_row;
	logic           covers;
	logic           last_sprite;

	assign hsync_rise = hsync && !hsync_last;
	assign spr_row = spr_ya - spr_y;
	assign covers = spr_enable && (spr_ya >= spr_y) && (spr_row < Y_W'(SPRITE_SIZE));
	assign last_sprite = (spr_index == LAST_INDEX);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			state_next <= S_IDLE;
			hsync_last <= 1'b0;
			swap <= 1'b0;
			line_done <= 1'b0;
			lb_wr.en <= 1'b0;
		end
		else
		begin
			hsync_last <= hsync;
			swap <= 1'b0;
			line_done <= 1'b0;
			lb_wr.en <= 1'b0;

			case (state)
				S_IDLE:
				begin
					// Edges that arrive while rendering are dropped here
					if (hsync_rise)
					begin
						swap <= 1'b1;
						spr_ya <= Y_W'(vcnt) + Y_W'(SPRITE_SIZE);
						lb_wr.addr <= '0;
						state <= S_CLEAR;
					end
				end

				S_CLEAR:
				begin
					// First cycle only raises the write and later cycles step the address
					lb_wr.data <= '0;
					if (lb_wr.en && lb_wr.addr == LAST_CLEAR)
					begin
						spr_index <= '0;
						state <= S_SETUP_Y;
					end
					else
					begin
						lb_wr.en <= 1'b1;
						if (lb_wr.en)
						begin
							lb_wr.addr <= lb_wr.addr + 1'b1;
						end
					end
				end

				S_SETUP_Y:
				begin
					spr_table_addr <= SPR_TABLE_ADDR_W'(spr_index * SPR_BYTES_PER_ENTRY);
					state <= S_WAIT;
					state_next <= S_READ_Y_UPPER;
				end

				// Covers the one-cycle read latency of the external memories
				S_WAIT:
				begin
					state <= state_next;
				end

				S_READ_Y_UPPER:
				begin
					spr_enable <= spr_table_data[SPR_ENABLE_BIT];
					spr_y[11:8] <= spr_table_data[3:0];
					spr_table_addr <= spr_table_addr + 1'b1;
					state <= S_WAIT;
					state_next <= S_READ_Y_LOWER;
				end

				S_READ_Y_LOWER:
				begin
					spr_y[7:0] <= spr_table_data;
					// Byte 2 address goes out now so the Y test hides its latency
					spr_table_addr <= spr_table_addr + 1'b1;
					state <= S_CHECK_Y;
				end

				S_CHECK_Y:
				begin
					if (covers)
					begin
						state <= S_READ_X_UPPER;
					end
					else if (last_sprite)
					begin
						state <= S_LINE_COMPLETE;
					end
					else
					begin
						spr_index <= spr_index + 1'b1;
						state <= S_SETUP_Y;
					end
				end

				S_READ_X_UPPER:
				begin
					spr_image <= spr_table_data[7:2];
					// Positions wrap at 512 and leave x[9] without effect
					spr_x[8] <= spr_table_data[0];
					spr_table_addr <= spr_table_addr + 1'b1;
					state <= S_WAIT;
					state_next <= S_READ_X_LOWER;
				end

				S_READ_X_LOWER:
				begin
					spr_x[7:0] <= spr_table_data;
					state <= S_SETUP_PIXEL;
				end

				S_SETUP_PIXEL:
				begin
					// Image base plus the row inside the sprite
					img_rom_addr <= {spr_image, spr_row[ROW_W-1:0], {ROW_W{1'b0}}};
					lb_wr.addr <= spr_x;
					pixel_index <= '0;
					state <= S_WAIT;
					state_next <= S_GET_PIXEL;
				end

				S_GET_PIXEL:
				begin
					if (pixel_index == PIX_W'(SPRITE_SIZE))
					begin
						if (last_sprite)
						begin
							state <= S_LINE_COMPLETE;
						end
						else
						begin
							spr_index <= spr_index + 1'b1;
							state <= S_SETUP_Y;
						end
					end
					else
					begin
						pal_addr <= img_rom_data[PAL_ADDR_W-1:0];
						img_rom_addr <= img_rom_addr + 1'b1;
						state <= S_WAIT;
						state_next <= S_STAGE_PIXEL;
					end
				end

				S_STAGE_PIXEL:
				begin
					if (pal_data.alpha)
					begin
						lb_wr.en <= 1'b1;
						lb_wr.data <= pal_data;
						state <= S_WRITE_PIXEL;
					end
					else
					begin
						// Transparent pixels keep whatever is already in the slot
						lb_wr.addr <= lb_wr.addr + 1'b1;
						pixel_index <= pixel_index + 1'b1;
						state <= S_GET_PIXEL;
					end
				end

				S_WRITE_PIXEL:
				begin
					lb_wr.addr <= lb_wr.addr + 1'b1;
					pixel_index <= pixel_index + 1'b1;
					state <= S_GET_PIXEL;
				end

				S_LINE_COMPLETE:
				begin
					line_done <= 1'b1;
					state <= S_IDLE;
				end

				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// Sprite edge length in pixels, both axes
	localparam int SPRITE_SIZE = 16;

	// Address width inside one line buffer slot
	localparam int LB_ADDR_W = 9;

	// External memory address widths
	localparam int SPR_TABLE_ADDR_W = 7;
	localparam int SPR_ROM_ADDR_W = 14;
	localparam int PAL_ADDR_W = 5;

	// Sprite table entry: 4 bytes, enable flag in bit 7 of byte 0
	localparam int SPR_BYTES_PER_ENTRY = 4;
	localparam int SPR_ENABLE_BIT = 7;

	// Palette ROM word and line buffer word, all zero means empty
	typedef struct packed {
		logic       alpha;
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} pal_color_t;

	// Display output pixel
	typedef struct packed {
		logic       alpha;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_pixel_t;

	// Horizontal and vertical screen counters
	typedef logic [8:0] screen_pos_t;

	// Scanner to line buffer write, address relative to the write slot
	typedef struct packed {
		logic                 en;
		logic [LB_ADDR_W-1:0] addr;
		pal_color_t           data;
	} lb_write_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sprite_engine -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- sim/sprite_engine_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_engine_sva (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            swap,
	input  wire logic            line_done,
	input  wire logic            clearing,
	input  sprite_pkg::lb_write_t lb_wr
);

	// Set by line_done, cleared when the next line starts
	logic done_seen = 1'b0;

	always @(posedge clk)
	begin
		if (!rst_n || swap)
			done_seen <= 1'b0;
		else if (line_done)
			done_seen <= 1'b1;
	end

	a_swap_single: assert property (@(posedge clk) disable iff (!rst_n) swap |=> !swap)
		else $error("swap stayed high for more than one cycle");

	// Only the clear pass writes words without alpha
	a_opaque_write: assert property (@(posedge clk) disable iff (!rst_n)
		(lb_wr.en && !lb_wr.data.alpha) |-> clearing)
		else $error("transparent word written outside the clear phase");

	a_quiet_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		done_seen |-> !lb_wr.en)
		else $error("line buffer written after line_done and before the next swap");

	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!swap && !line_done && !lb_wr.en))
		else $error("scanner outputs active during reset");

endmodule

bind sprite_line_scanner sprite_engine_sva sprite_engine_sva_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.swap      (swap),
	.line_done (line_done),
	.clearing  (state == S_CLEAR),
	.lb_wr     (lb_wr)
);

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset released on a rising edge once the hold time has passed
	initial
	begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_engine;

	import sprite_pkg::*;

	localparam int SPRITE_COUNT = 8;
	localparam int LINE_LENGTH = 352;
	localparam int NUM_TESTS = 12;
	localparam int SWEEP_LEN = LINE_LENGTH - SPRITE_SIZE;
	// Clear pass plus the slowest path through every table entry
	localparam int DONE_BOUND = LINE_LENGTH + 8 + SPRITE_COUNT * (12 + 4 * SPRITE_SIZE);
	localparam longint WATCHDOG_NS =
		longint'(NUM_TESTS) * (3 * DONE_BOUND + SWEEP_LEN + 64) * 100 * 2;

	logic                        clk;
	logic                        rst_n;
	logic                        hsync = 1'b0;
	screen_pos_t                 vcnt = '0;
	screen_pos_t                 hcnt = '0;
	logic [SPR_TABLE_ADDR_W-1:0] spr_table_addr;
	logic [7:0]                  spr_table_data = '0;
	logic [SPR_ROM_ADDR_W-1:0]   img_rom_addr;
	logic [7:0]                  img_rom_data = '0;
	logic [PAL_ADDR_W-1:0]       pal_addr;
	pal_color_t                  pal_data = '0;
	rgb_pixel_t                  pixel;
	logic                        line_done;

	logic [7:0] table_mem [1 << SPR_TABLE_ADDR_W];
	logic [7:0] image_mem [1 << SPR_ROM_ADDR_W];
	pal_color_t pal_mem [1 << PAL_ADDR_W];
	// Expected content of the slot that gets displayed
	pal_color_t model_line [1 << LB_ADDR_W];

	int done_count = 0;
	int check_count = 0;
	int error_count = 0;
	int failed_tests = 0;
	string test_names [6] = '{"all disabled", "single sprite", "transparency",
		"overlap", "y coverage", "busy hsync"};

	tb_clock_gen #(
		.PERIOD_NS    (100),
		.RESET_CYCLES (3)
	) tb_clock_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	sprite_engine_top #(
		.SPRITE_COUNT (SPRITE_COUNT),
		.LINE_LENGTH  (LINE_LENGTH)
	) sprite_engine_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.hcnt           (hcnt),
		.spr_table_addr (spr_table_addr),
		.spr_table_data (spr_table_data),
		.img_rom_addr   (img_rom_addr),
		.img_rom_data   (img_rom_data),
		.pal_addr       (pal_addr),
		.pal_data       (pal_data),
		.pixel          (pixel),
		.line_done      (line_done)
	);

	// External memories answer one cycle after the address is registered
	always @(posedge clk)
	begin
		spr_table_data <= table_mem[spr_table_addr];
		img_rom_data <= image_mem[img_rom_addr];
		pal_data <= pal_mem[pal_addr];
	end

	always @(posedge clk)
	begin
		if (rst_n && line_done)
			done_count <= done_count + 1;
	end

	// Scales 5 bits to 8 by moving them up and filling the low bits from the top
	function automatic logic [7:0] widen_channel(input logic [4:0] v);
		return 8'(int'(v) * 8 + int'(v) / 4);
	endfunction

	function automatic rgb_pixel_t expand_color(input pal_color_t c);
		rgb_pixel_t px;
		px.alpha = c.alpha;
		px.red = widen_channel(c.red);
		px.green = widen_channel(c.green);
		px.blue = widen_channel(c.blue);
		return px;
	endfunction

	task automatic check_pixel(input int column, input rgb_pixel_t actual,
		input rgb_pixel_t expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %0t: column %0d pixel %h, expected %h",
				$time, column, actual, expected);
		end
	endtask

	task automatic check_done(input int start, input int bound);
		int cycles;
		cycles = 0;
		while (done_count == start && cycles < bound)
		begin
			@(posedge clk);
			cycles++;
		end
		check_count++;
		if (done_count == start)
		begin
			error_count++;
			$display("Timeout at %0t: line_done did not arrive within %0d cycles", $time, bound);
		end
		else
		begin
			repeat (SPRITE_SIZE) @(posedge clk);
			if (done_count != start + 1)
			begin
				error_count++;
				$display("[ERROR] %0t: line_done pulsed %0d times, expected once",
					$time, done_count - start);
			end
		end
	endtask

	task automatic pulse_hsync(input screen_pos_t line);
		@(posedge clk);
		hsync <= 1'b1;
		vcnt <= line;
		@(posedge clk);
		hsync <= 1'b0;
	endtask

	task automatic place_sprite(input int idx, input logic enable, input int y, input int x);
		logic [7:0] attr;
		attr = {4'($urandom), 4'(y >> 8)};
		attr[SPR_ENABLE_BIT] = enable;
		table_mem[idx * SPR_BYTES_PER_ENTRY] = attr;
		table_mem[idx * SPR_BYTES_PER_ENTRY + 1] = 8'(y);
		table_mem[idx * SPR_BYTES_PER_ENTRY + 2] = {6'($urandom), 2'(x >> 8)};
		table_mem[idx * SPR_BYTES_PER_ENTRY + 3] = 8'(x);
	endtask

	task automatic fill_memories(input int kind, input int ya);
		int base;
		int pick;
		int x;
		int y;
		logic enable;
		base = $urandom_range(SPRITE_SIZE, LINE_LENGTH - 3 * SPRITE_SIZE);
		pick = $urandom_range(0, SPRITE_COUNT - 1);
		foreach (image_mem[i])
			image_mem[i] = 8'($urandom);
		foreach (pal_mem[i])
		begin
			pal_mem[i] = 16'($urandom);
			if (kind == 1 || kind == 3)
				pal_mem[i].alpha = 1'b1;
		end
		foreach (table_mem[i])
			table_mem[i] = 8'($urandom);
		for (int s = 0; s < SPRITE_COUNT; s++)
		begin
			// Covering sprites clustered so that they overlap
			enable = 1'b1;
			y = ya - $urandom_range(0, SPRITE_SIZE - 1);
			x = base + $urandom_range(0, 2 * SPRITE_SIZE);
			case (kind)
				0: enable = 1'b0;
				1:
				begin
					enable = (s == pick);
					x = $urandom_range(SPRITE_SIZE, LINE_LENGTH - SPRITE_SIZE);
				end
				4, 5:
				begin
					// Straddles both ends of the covering range
					y = ya - SPRITE_SIZE - 1 + $urandom_range(0, SPRITE_SIZE + 2);
					x = $urandom_range(0, 1023);
					if (kind == 5)
						enable = 1'($urandom);
				end
				default: ;
			endcase
			place_sprite(s, enable, y, x);
		end
	endtask

	task automatic build_model(input int ya);
		logic [7:0] b0;
		logic [7:0] b2;
		logic [7:0] rom_byte;
		int y;
		int x;
		int row;
		pal_color_t color;
		foreach (model_line[i])
			model_line[i] = '0;
		for (int s = 0; s < SPRITE_COUNT; s++)
		begin
			b0 = table_mem[s * SPR_BYTES_PER_ENTRY];
			b2 = table_mem[s * SPR_BYTES_PER_ENTRY + 2];
			y = {b0[3:0], table_mem[s * SPR_BYTES_PER_ENTRY + 1]};
			x = {b2[1:0], table_mem[s * SPR_BYTES_PER_ENTRY + 3]};
			row = ya - y;
			if (!b0[SPR_ENABLE_BIT] || row < 0 || row >= SPRITE_SIZE)
				continue;
			// Later sprites overwrite earlier ones
			for (int p = 0; p < SPRITE_SIZE; p++)
			begin
				rom_byte = image_mem[b2[7:2] * 256 + row * SPRITE_SIZE + p];
				color = pal_mem[rom_byte[4:0]];
				if (color.alpha)
					model_line[(x + p) % 512] = color;
			end
		end
	endtask

	// Pixel for a column is sampled two edges after hcnt is driven
	task automatic sweep_line();
		for (int i = 0; i < SWEEP_LEN + 2; i++)
		begin
			@(posedge clk);
			if (i >= 2)
				check_pixel(i - 2, pixel, expand_color(model_line[i - 2 + SPRITE_SIZE]));
			if (i < SWEEP_LEN)
				hcnt <= screen_pos_t'(i);
		end
	endtask

	initial
	begin
		int errors_before;
		int kind;
		int start;
		int ya;
		screen_pos_t line;
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(50));
		wait (rst_n === 1'b1);
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			errors_before = error_count;
			kind = t % 6;
			line = screen_pos_t'($urandom_range(8, 400));
			ya = int'(line) + SPRITE_SIZE;
			fill_memories(kind, ya);
			build_model(ya);
			start = done_count;
			pulse_hsync(line);
			if (kind == 5)
			begin
				// Lands in the clear phase
				repeat (20) @(posedge clk);
				pulse_hsync(screen_pos_t'($urandom_range(0, 400)));
			end
			check_done(start, DONE_BOUND);
			start = done_count;
			pulse_hsync(screen_pos_t'($urandom_range(0, 400)));
			sweep_line();
			check_done(start, DONE_BOUND);
			if (error_count != errors_before)
				failed_tests++;
			$display("Test %0d (%s): %s", t, test_names[kind],
				(error_count == errors_before) ? "passed" : "failed");
		end
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			NUM_TESTS, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/sprite_pkg.sv
rtl/sprite_line_scanner.sv
rtl/sprite_line_buffer.sv
rtl/sprite_engine_top.sv
sim/tb_clock_gen.sv
sim/sprite_engine_sva.sv
sim/tb_sprite_engine.sv
